/* all.f */
+incdir+include
verilog/rs_pkg.sv
verilog/dispatch_router.sv
verilog/reservation_station.sv
verilog/rs_dispatch_top.sv
test/tb_rs_dispatch.sv

/* include/rs_settings.svh */
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// Physical register tag width
`define RS_TAG_W 8

// Operand, pc and immediate width
`define RS_DATA_W 32

// Entries per reservation station
`define ALU_RS_DEPTH 4
`define MUL_RS_DEPTH 2
`define DIV_RS_DEPTH 2
`define BR_RS_DEPTH 4

`endif

/* test/rs_dispatch_vectors.txt */
# D opcode f3 f7 pc op1 op2 s1tag s2tag srdy rd imm inst m2r mrd mwr aluop as1 as2 jmp br pt btb
# W tag data / E port op1 op2 s1tag s2tag srdy, then the payload fields of that port in order
# ADD, SUB, LW, SW, ADDI to the ALU port
D 33 0 00 1000 5 7 01 02 3 10 0 1 0 0 0 0 0 0 0 0 0 0
E alu 5 7 01 02 3 0 0 0 0 0 0 0 1000 0 10 1
D 33 0 20 1004 9 4 03 04 3 11 0 2 0 0 0 1 0 0 0 0 0 0
E alu 9 4 03 04 3 0 1 0 0 0 0 0 1004 0 11 2
D 03 2 00 1008 100 0 05 00 3 12 10 3 1 1 0 0 0 1 0 0 0 0
E alu 100 0 05 00 3 2 0 0 1 1 1 0 1008 10 12 3
D 23 2 00 100c 200 abcd 06 07 3 00 8 4 0 0 1 0 0 1 0 0 0 0
E alu 200 abcd 06 07 3 2 0 0 1 0 0 1 100c 8 00 4
D 13 0 00 1010 7 0 08 00 3 13 fffffffc 5 0 0 0 0 0 1 0 0 0 0
E alu 7 0 08 00 3 0 0 0 1 0 0 0 1010 fffffffc 13 5
# Bubble, accepted and dropped
D 00 0 00 0 dead beef 00 00 3 00 0 6 0 0 0 0 0 0 0 0 0 0
# MUL and MULH, then DIV and REM
D 33 0 01 1014 3 4 09 0a 3 14 0 7 0 0 0 0 0 0 0 0 0 0
E mul 3 4 09 0a 3 0 14 7
D 33 1 01 1018 6 2 0b 0c 3 15 0 8 0 0 0 0 0 0 0 0 0 0
E mul 6 2 0b 0c 3 1 15 8
D 33 4 01 101c 64 5 0d 0e 3 16 0 9 0 0 0 0 0 0 0 0 0 0
E div 64 5 0d 0e 3 4 16 9
D 33 6 01 1020 65 5 0f 10 3 17 0 a 0 0 0 0 0 0 0 0 0 0
E div 65 5 0f 10 3 6 17 a
# JAL, JALR, BEQ to the branch port
D 6f 0 00 1024 0 0 00 00 3 18 40 b 0 0 0 0 0 0 1 0 1 1
E br 0 0 00 00 3 0 1 0 1 1 1024 40 18 b
D 67 0 00 1028 2000 0 19 00 3 1a 4 c 0 0 0 0 0 0 1 0 0 0
E br 2000 0 19 00 3 0 1 0 0 0 1028 4 1a c
D 63 0 00 102c 11 11 1b 1c 3 00 fffffff0 d 0 0 0 0 0 0 0 1 0 1
E br 11 11 1b 1c 3 0 0 1 0 1 102c fffffff0 00 d
# Older ADD waits on tag 40 while the younger ADD is ready
D 33 0 00 1030 21 0 22 40 1 30 0 e 0 0 0 0 0 0 0 0 0 0
E alu 21 12345678 22 40 3 0 0 0 0 0 0 0 1030 0 30 e
D 33 0 00 1034 1 2 23 24 3 31 0 f 0 0 0 0 0 0 0 0 0 0
E alu 1 2 23 24 3 0 0 0 0 0 0 0 1034 0 31 f
# MUL waits on both sources, BNE has source 1 ready under tag 40
D 33 0 01 1038 0 0 41 42 0 32 0 10 0 0 0 0 0 0 0 0 0 0
E mul aaaa5555 bbbb6666 41 42 3 0 32 10
D 63 1 00 103c 77 0 40 42 1 00 20 11 0 0 0 0 0 0 0 1 0 0
E br 77 bbbb6666 40 42 3 1 0 1 0 0 103c 20 00 11
W 40 12345678
W 41 aaaa5555
W 42 bbbb6666
# Three divides into the two-entry divide station, then an OR behind them
D 33 5 01 1040 10 2 43 44 3 33 0 12 0 0 0 0 0 0 0 0 0 0
E div 10 2 43 44 3 5 33 12
D 33 6 01 1044 11 3 45 46 3 34 0 13 0 0 0 0 0 0 0 0 0 0
E div 11 3 45 46 3 6 34 13
D 33 7 01 1048 12 4 47 48 3 35 0 14 0 0 0 0 0 0 0 0 0 0
E div 12 4 47 48 3 7 35 14
D 33 6 00 104c f0 0f 49 4a 3 36 0 15 0 0 0 3 0 0 0 0 0 0
E alu f0 0f 49 4a 3 6 3 0 0 0 0 0 104c 0 36 15

/* test/tb_rs_dispatch.sv */
`include "rs_settings.svh"

module tb_rs_dispatch;

    localparam int          DISPATCH_TIMEOUT = 200;
    localparam int          DRAIN_TIMEOUT    = 1000;
    localparam logic [31:0] LFSR_SEED        = 32'hed8c_f55c;

    logic                     clk;
    logic                     reset;
    logic                     dispatch_valid;
    rs_pkg::dispatch_t        dispatch;
    logic                     dispatch_ready;
    rs_pkg::cdb_t             cdb;
    logic                     alu_issue_valid;
    logic                     alu_issue_ready;
    rs_pkg::rs_operands_t     alu_issue_ops;
    rs_pkg::alu_payload_t     alu_issue_payload;
    logic                     mul_issue_valid;
    logic                     mul_issue_ready;
    rs_pkg::rs_operands_t     mul_issue_ops;
    rs_pkg::muldiv_payload_t  mul_issue_payload;
    logic                     div_issue_valid;
    logic                     div_issue_ready;
    rs_pkg::rs_operands_t     div_issue_ops;
    rs_pkg::muldiv_payload_t  div_issue_payload;
    logic                     br_issue_valid;
    logic                     br_issue_ready;
    rs_pkg::rs_operands_t     br_issue_ops;
    rs_pkg::branch_payload_t  br_issue_payload;

    // Expected issues per port, in dispatch order
    rs_pkg::rs_operands_t     alu_ops_q [$];
    rs_pkg::alu_payload_t     alu_pl_q [$];
    rs_pkg::rs_operands_t     mul_ops_q [$];
    rs_pkg::muldiv_payload_t  mul_pl_q [$];
    rs_pkg::rs_operands_t     div_ops_q [$];
    rs_pkg::muldiv_payload_t  div_pl_q [$];
    rs_pkg::rs_operands_t     br_ops_q [$];
    rs_pkg::branch_payload_t  br_pl_q [$];

    int                       fd;
    logic [31:0]              v [22];          // Hex fields of the current command
    logic [31:0]              lfsr_state;

    rs_dispatch_top i_rs_dispatch_top (
        .clk               (clk),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .dispatch          (dispatch),
        .dispatch_ready    (dispatch_ready),
        .cdb               (cdb),
        .alu_issue_valid   (alu_issue_valid),
        .alu_issue_ready   (alu_issue_ready),
        .alu_issue_ops     (alu_issue_ops),
        .alu_issue_payload (alu_issue_payload),
        .mul_issue_valid   (mul_issue_valid),
        .mul_issue_ready   (mul_issue_ready),
        .mul_issue_ops     (mul_issue_ops),
        .mul_issue_payload (mul_issue_payload),
        .div_issue_valid   (div_issue_valid),
        .div_issue_ready   (div_issue_ready),
        .div_issue_ops     (div_issue_ops),
        .div_issue_payload (div_issue_payload),
        .br_issue_valid    (br_issue_valid),
        .br_issue_ready    (br_issue_ready),
        .br_issue_ops      (br_issue_ops),
        .br_issue_payload  (br_issue_payload)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic compare_operands(input string name, input rs_pkg::rs_operands_t got,
                                    input rs_pkg::rs_operands_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_alu(input string name, input rs_pkg::alu_payload_t got,
                               input rs_pkg::alu_payload_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_muldiv(input string name, input rs_pkg::muldiv_payload_t got,
                                  input rs_pkg::muldiv_payload_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic compare_branch(input string name, input rs_pkg::branch_payload_t got,
                                  input rs_pkg::branch_payload_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // Galois LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic random_bit(output logic bit_out);
        lfsr_state = lfsr_next(lfsr_state);
        bit_out    = lfsr_state[0];
    endtask

    // Random back-pressure on every issue port
    always @(negedge clk) begin
        random_bit(alu_issue_ready);
        random_bit(mul_issue_ready);
        random_bit(div_issue_ready);
        random_bit(br_issue_ready);
    end

    task automatic check_alu_issue();
        if (alu_ops_q.size() == 0) begin
            report_failure("alu port issued an instruction that was not expected");
        end else begin
            compare_operands("alu_issue_ops", alu_issue_ops, alu_ops_q.pop_front());
            compare_alu("alu_issue_payload", alu_issue_payload, alu_pl_q.pop_front());
        end
    endtask

    task automatic check_mul_issue();
        if (mul_ops_q.size() == 0) begin
            report_failure("mul port issued an instruction that was not expected");
        end else begin
            compare_operands("mul_issue_ops", mul_issue_ops, mul_ops_q.pop_front());
            compare_muldiv("mul_issue_payload", mul_issue_payload, mul_pl_q.pop_front());
        end
    endtask

    task automatic check_div_issue();
        if (div_ops_q.size() == 0) begin
            report_failure("div port issued an instruction that was not expected");
        end else begin
            compare_operands("div_issue_ops", div_issue_ops, div_ops_q.pop_front());
            compare_muldiv("div_issue_payload", div_issue_payload, div_pl_q.pop_front());
        end
    endtask

    task automatic check_br_issue();
        if (br_ops_q.size() == 0) begin
            report_failure("br port issued an instruction that was not expected");
        end else begin
            compare_operands("br_issue_ops", br_issue_ops, br_ops_q.pop_front());
            compare_branch("br_issue_payload", br_issue_payload, br_pl_q.pop_front());
        end
    endtask

    // Transfers happen where valid and ready are both high at the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (alu_issue_valid && alu_issue_ready) check_alu_issue();
            if (mul_issue_valid && mul_issue_ready) check_mul_issue();
            if (div_issue_valid && div_issue_ready) check_div_issue();
            if (br_issue_valid && br_issue_ready) check_br_issue();
        end
    end

    task automatic read_fields(input int count);
        for (int i = 0; i < count; i++) begin
            if ($fscanf(fd, " %h", v[i]) != 1) begin
                report_failure("malformed line in the vector file");
            end
        end
    endtask

    function automatic rs_pkg::rs_operands_t ops_from_fields();
        rs_pkg::rs_operands_t ops;
        ops.operand1  = v[0];
        ops.operand2  = v[1];
        ops.src1_tag  = v[2][`RS_TAG_W-1:0];
        ops.src2_tag  = v[3][`RS_TAG_W-1:0];
        ops.src_ready = v[4][1:0];
        return ops;
    endfunction

    // Hold one instruction on the dispatch port until it is accepted
    task automatic apply_dispatch();
        int   cycles;
        logic accepted;
        read_fields(22);
        dispatch.opcode     = v[0][6:0];
        dispatch.funct3     = v[1][2:0];
        dispatch.funct7     = v[2][6:0];
        dispatch.pc         = v[3];
        dispatch.operand1   = v[4];
        dispatch.operand2   = v[5];
        dispatch.src1_tag   = v[6][`RS_TAG_W-1:0];
        dispatch.src2_tag   = v[7][`RS_TAG_W-1:0];
        dispatch.src_ready  = v[8][1:0];
        dispatch.rd_tag     = v[9][`RS_TAG_W-1:0];
        dispatch.immediate  = v[10];
        dispatch.inst_num   = v[11];
        dispatch.mem_to_reg = v[12][0];
        dispatch.mem_read   = v[13][0];
        dispatch.mem_write  = v[14][0];
        dispatch.alu_op     = v[15][3:0];
        dispatch.alu_src1   = v[16][0];
        dispatch.alu_src2   = v[17][0];
        dispatch.jump       = v[18][0];
        dispatch.branch     = v[19][0];
        dispatch.pred_taken = v[20][0];
        dispatch.btb_hit    = v[21][0];
        dispatch_valid      = 1'b1;
        accepted = 1'b0;
        cycles   = 0;
        while (!accepted && cycles < DISPATCH_TIMEOUT) begin
            @(posedge clk);
            accepted = dispatch_ready;
            cycles++;
        end
        if (!accepted) begin
            report_failure("dispatch was not accepted before the timeout");
        end else begin
            @(negedge clk);
            dispatch_valid = 1'b0;
        end
    endtask

    // One cycle of CDB broadcast
    task automatic apply_wakeup();
        read_fields(2);
        cdb.valid = 1'b1;
        cdb.tag   = v[0][`RS_TAG_W-1:0];
        cdb.data  = v[1];
        @(negedge clk);
        cdb.valid = 1'b0;
    endtask

    task automatic push_expected();
        string                    port;
        rs_pkg::alu_payload_t     alu_pl;
        rs_pkg::muldiv_payload_t  md_pl;
        rs_pkg::branch_payload_t  br_pl;
        if ($fscanf(fd, " %s", port) != 1) begin
            report_failure("missing port name in the vector file");
        end else if (port == "alu") begin
            read_fields(16);
            alu_pl.funct3     = v[5][2:0];
            alu_pl.alu_op     = v[6][3:0];
            alu_pl.alu_src1   = v[7][0];
            alu_pl.alu_src2   = v[8][0];
            alu_pl.mem_to_reg = v[9][0];
            alu_pl.mem_read   = v[10][0];
            alu_pl.mem_write  = v[11][0];
            alu_pl.pc         = v[12];
            alu_pl.immediate  = v[13];
            alu_pl.rd_tag     = v[14][`RS_TAG_W-1:0];
            alu_pl.inst_num   = v[15];
            alu_ops_q.push_back(ops_from_fields());
            alu_pl_q.push_back(alu_pl);
        end else if (port == "mul" || port == "div") begin
            read_fields(8);
            md_pl.funct3   = v[5][2:0];
            md_pl.rd_tag   = v[6][`RS_TAG_W-1:0];
            md_pl.inst_num = v[7];
            if (port == "mul") begin
                mul_ops_q.push_back(ops_from_fields());
                mul_pl_q.push_back(md_pl);
            end else begin
                div_ops_q.push_back(ops_from_fields());
                div_pl_q.push_back(md_pl);
            end
        end else if (port == "br") begin
            read_fields(14);
            br_pl.funct3     = v[5][2:0];
            br_pl.jump       = v[6][0];
            br_pl.branch     = v[7][0];
            br_pl.pred_taken = v[8][0];
            br_pl.btb_hit    = v[9][0];
            br_pl.pc         = v[10];
            br_pl.immediate  = v[11];
            br_pl.rd_tag     = v[12][`RS_TAG_W-1:0];
            br_pl.inst_num   = v[13];
            br_ops_q.push_back(ops_from_fields());
            br_pl_q.push_back(br_pl);
        end else begin
            report_failure($sformatf("unknown port name %s in the vector file", port));
        end
    endtask

    function automatic logic queues_pending();
        return (alu_ops_q.size() + mul_ops_q.size() + div_ops_q.size() + br_ops_q.size()) != 0;
    endfunction

    initial begin
        string cmd;
        string rest;
        int    code;
        int    cycles;
        logic  done;
        reset           = 1'b1;
        dispatch_valid  = 1'b0;
        dispatch        = '0;
        cdb             = '0;
        alu_issue_ready = 1'b0;
        mul_issue_ready = 1'b0;
        div_issue_ready = 1'b0;
        br_issue_ready  = 1'b0;
        lfsr_state      = LFSR_SEED;
        fd = $fopen("test/rs_dispatch_vectors.txt", "r");
        if (fd == 0) begin
            report_failure("could not open test/rs_dispatch_vectors.txt");
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        done  = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %s", cmd);
            if (code != 1) begin
                done = 1'b1;                        // End of file
            end else if (cmd.substr(0, 0) == "#") begin
                code = $fgets(rest, fd);            // Comment line
            end else if (cmd == "D") begin
                apply_dispatch();
            end else if (cmd == "W") begin
                apply_wakeup();
            end else if (cmd == "E") begin
                push_expected();
            end else begin
                report_failure($sformatf("unknown command %s in the vector file", cmd));
            end
        end
        $fclose(fd);
        cycles = 0;
        while (queues_pending() && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (queues_pending()) begin
            report_failure("expected issues were still pending at the end of the run");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

/* verilog/dispatch_router.sv */
module dispatch_router (
    input  logic                     dispatch_valid,
    input  rs_pkg::dispatch_t        dispatch,
    output logic                     dispatch_ready,

    output logic                     alu_write_valid,
    input  logic                     alu_write_ready,
    output rs_pkg::rs_operands_t     alu_write_ops,
    output rs_pkg::alu_payload_t     alu_write_payload,

    output logic                     mul_write_valid,
    input  logic                     mul_write_ready,
    output rs_pkg::rs_operands_t     mul_write_ops,
    output rs_pkg::muldiv_payload_t  mul_write_payload,

    output logic                     div_write_valid,
    input  logic                     div_write_ready,
    output rs_pkg::rs_operands_t     div_write_ops,
    output rs_pkg::muldiv_payload_t  div_write_payload,

    output logic                     br_write_valid,
    input  logic                     br_write_ready,
    output rs_pkg::rs_operands_t     br_write_ops,
    output rs_pkg::branch_payload_t  br_write_payload
);

    logic                  sel_alu;
    logic                  sel_mul;
    logic                  sel_div;
    logic                  sel_br;
    logic                  is_bubble;
    rs_pkg::rs_operands_t  ops;

    // Station select from opcode, funct7 and funct3
    always_comb begin
        sel_alu   = 1'b0;
        sel_mul   = 1'b0;
        sel_div   = 1'b0;
        sel_br    = 1'b0;
        is_bubble = 1'b0;
        case (dispatch.opcode)
            rs_pkg::OPC_BUBBLE: begin
                is_bubble = 1'b1;                    // Accepted and dropped
            end
            rs_pkg::OPC_OP: begin
                if (dispatch.funct7 == rs_pkg::FUNCT7_MULDIV) begin
                    sel_mul = ~dispatch.funct3[2];   // MUL, MULH, MULHSU, MULHU
                    sel_div = dispatch.funct3[2];    // DIV, DIVU, REM, REMU
                end else begin
                    sel_alu = 1'b1;
                end
            end
            rs_pkg::OPC_JAL, rs_pkg::OPC_JALR, rs_pkg::OPC_BRANCH: begin
                sel_br = 1'b1;
            end
            default: begin
                sel_alu = 1'b1;                      // Loads, stores, immediates, LUI
            end
        endcase
    end

    assign dispatch_ready = is_bubble
                          | (sel_alu & alu_write_ready)
                          | (sel_mul & mul_write_ready)
                          | (sel_div & div_write_ready)
                          | (sel_br  & br_write_ready);

    assign alu_write_valid = dispatch_valid & sel_alu;
    assign mul_write_valid = dispatch_valid & sel_mul;
    assign div_write_valid = dispatch_valid & sel_div;
    assign br_write_valid  = dispatch_valid & sel_br;

    // Operand half is the same layout for every station
    assign ops.operand1  = dispatch.operand1;
    assign ops.operand2  = dispatch.operand2;
    assign ops.src1_tag  = dispatch.src1_tag;
    assign ops.src2_tag  = dispatch.src2_tag;
    assign ops.src_ready = dispatch.src_ready;

    assign alu_write_ops = ops;
    assign mul_write_ops = ops;
    assign div_write_ops = ops;
    assign br_write_ops  = ops;

    always_comb begin
        alu_write_payload.funct3     = dispatch.funct3;
        alu_write_payload.alu_op     = dispatch.alu_op;
        alu_write_payload.alu_src1   = dispatch.alu_src1;
        alu_write_payload.alu_src2   = dispatch.alu_src2;
        alu_write_payload.mem_to_reg = dispatch.mem_to_reg;
        alu_write_payload.mem_read   = dispatch.mem_read;
        alu_write_payload.mem_write  = dispatch.mem_write;
        alu_write_payload.pc         = dispatch.pc;
        alu_write_payload.immediate  = dispatch.immediate;
        alu_write_payload.rd_tag     = dispatch.rd_tag;
        alu_write_payload.inst_num   = dispatch.inst_num;

        mul_write_payload.funct3     = dispatch.funct3;
        mul_write_payload.rd_tag     = dispatch.rd_tag;
        mul_write_payload.inst_num   = dispatch.inst_num;
        div_write_payload            = mul_write_payload;   // Same fields for divide

        br_write_payload.funct3      = dispatch.funct3;
        br_write_payload.jump        = dispatch.jump;
        br_write_payload.branch      = dispatch.branch;
        br_write_payload.pred_taken  = dispatch.pred_taken;
        br_write_payload.btb_hit     = dispatch.btb_hit;
        br_write_payload.pc          = dispatch.pc;
        br_write_payload.immediate   = dispatch.immediate;
        br_write_payload.rd_tag      = dispatch.rd_tag;
        br_write_payload.inst_num    = dispatch.inst_num;
    end

endmodule

/* verilog/reservation_station.sv */
module reservation_station #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = rs_pkg::muldiv_payload_t
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  write_valid,
    output logic                  write_ready,
    input  rs_pkg::rs_operands_t  write_ops,
    input  payload_t              write_payload,

    input  rs_pkg::cdb_t          cdb,

    output logic                  issue_valid,
    input  logic                  issue_ready,
    output rs_pkg::rs_operands_t  issue_ops,
    output payload_t              issue_payload
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    rs_pkg::rs_operands_t  ops_q [DEPTH];       // Age ordered from head
    payload_t              payload_q [DEPTH];
    logic [PTR_W-1:0]      head;
    logic [PTR_W-1:0]      tail;
    logic [CNT_W-1:0]      count;
    logic                  do_write;
    logic                  do_issue;

    // Capture a broadcast result into any source still waiting on its tag
    function automatic rs_pkg::rs_operands_t wakeup(input rs_pkg::rs_operands_t ops,
                                                     input rs_pkg::cdb_t bus);
        rs_pkg::rs_operands_t woken;
        woken = ops;
        if (bus.valid && !ops.src_ready[0] && ops.src1_tag == bus.tag) begin
            woken.operand1     = bus.data;
            woken.src_ready[0] = 1'b1;
        end
        if (bus.valid && !ops.src_ready[1] && ops.src2_tag == bus.tag) begin
            woken.operand2     = bus.data;
            woken.src_ready[1] = 1'b1;
        end
        return woken;
    endfunction

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign write_ready   = (count != CNT_W'(DEPTH));
    assign issue_ops     = ops_q[head];
    assign issue_payload = payload_q[head];
    assign issue_valid   = (count != '0) && (&ops_q[head].src_ready);   // Head only

    assign do_write = write_valid & write_ready;
    assign do_issue = issue_valid & issue_ready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                tail <= next_ptr(tail);
            end
            if (do_issue) begin
                head <= next_ptr(head);
            end
            case ({do_write, do_issue})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;             // Both or neither
            endcase
        end
    end

    // Entry storage with wakeup on every slot and on the entry being written
    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            ops_q[i] <= wakeup(ops_q[i], cdb);
        end
        if (do_write) begin
            ops_q[tail]     <= wakeup(write_ops, cdb);
            payload_q[tail] <= write_payload;
        end
    end

    // Occupancy never passes DEPTH so no write lands on a live entry
    a_no_write_full: assert property (@(posedge clk) disable iff (reset)
        count <= CNT_W'(DEPTH))
        else $error("reservation_station: write accepted while full");

    // A stalled head stays issuable with both sources ready
    a_issue_ready: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !issue_ready) |=> issue_valid && (&issue_ops.src_ready))
        else $error("reservation_station: head lost readiness under back-pressure");

    a_issue_stable: assert property (@(posedge clk) disable iff (reset)
        (issue_valid && !issue_ready) |=> $stable(issue_ops) && $stable(issue_payload))
        else $error("reservation_station: issue outputs changed under back-pressure");

endmodule

/* verilog/rs_dispatch_top.sv */
`include "rs_settings.svh"

module rs_dispatch_top (
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     dispatch_valid,
    input  rs_pkg::dispatch_t        dispatch,
    output logic                     dispatch_ready,

    input  rs_pkg::cdb_t             cdb,

    output logic                     alu_issue_valid,
    input  logic                     alu_issue_ready,
    output rs_pkg::rs_operands_t     alu_issue_ops,
    output rs_pkg::alu_payload_t     alu_issue_payload,

    output logic                     mul_issue_valid,
    input  logic                     mul_issue_ready,
    output rs_pkg::rs_operands_t     mul_issue_ops,
    output rs_pkg::muldiv_payload_t  mul_issue_payload,

    output logic                     div_issue_valid,
    input  logic                     div_issue_ready,
    output rs_pkg::rs_operands_t     div_issue_ops,
    output rs_pkg::muldiv_payload_t  div_issue_payload,

    output logic                     br_issue_valid,
    input  logic                     br_issue_ready,
    output rs_pkg::rs_operands_t     br_issue_ops,
    output rs_pkg::branch_payload_t  br_issue_payload
);

    logic                     alu_write_valid;
    logic                     alu_write_ready;
    rs_pkg::rs_operands_t     alu_write_ops;
    rs_pkg::alu_payload_t     alu_write_payload;
    logic                     mul_write_valid;
    logic                     mul_write_ready;
    rs_pkg::rs_operands_t     mul_write_ops;
    rs_pkg::muldiv_payload_t  mul_write_payload;
    logic                     div_write_valid;
    logic                     div_write_ready;
    rs_pkg::rs_operands_t     div_write_ops;
    rs_pkg::muldiv_payload_t  div_write_payload;
    logic                     br_write_valid;
    logic                     br_write_ready;
    rs_pkg::rs_operands_t     br_write_ops;
    rs_pkg::branch_payload_t  br_write_payload;

    dispatch_router u_router (
        .dispatch_valid    (dispatch_valid),
        .dispatch          (dispatch),
        .dispatch_ready    (dispatch_ready),
        .alu_write_valid   (alu_write_valid),
        .alu_write_ready   (alu_write_ready),
        .alu_write_ops     (alu_write_ops),
        .alu_write_payload (alu_write_payload),
        .mul_write_valid   (mul_write_valid),
        .mul_write_ready   (mul_write_ready),
        .mul_write_ops     (mul_write_ops),
        .mul_write_payload (mul_write_payload),
        .div_write_valid   (div_write_valid),
        .div_write_ready   (div_write_ready),
        .div_write_ops     (div_write_ops),
        .div_write_payload (div_write_payload),
        .br_write_valid    (br_write_valid),
        .br_write_ready    (br_write_ready),
        .br_write_ops      (br_write_ops),
        .br_write_payload  (br_write_payload)
    );

    reservation_station #(
        .DEPTH     (`ALU_RS_DEPTH),
        .payload_t (rs_pkg::alu_payload_t)
    ) u_alu_rs (
        .clk           (clk),
        .reset         (reset),
        .write_valid   (alu_write_valid),
        .write_ready   (alu_write_ready),
        .write_ops     (alu_write_ops),
        .write_payload (alu_write_payload),
        .cdb           (cdb),
        .issue_valid   (alu_issue_valid),
        .issue_ready   (alu_issue_ready),
        .issue_ops     (alu_issue_ops),
        .issue_payload (alu_issue_payload)
    );

    reservation_station #(
        .DEPTH     (`MUL_RS_DEPTH),
        .payload_t (rs_pkg::muldiv_payload_t)
    ) u_mul_rs (
        .clk           (clk),
        .reset         (reset),
        .write_valid   (mul_write_valid),
        .write_ready   (mul_write_ready),
        .write_ops     (mul_write_ops),
        .write_payload (mul_write_payload),
        .cdb           (cdb),
        .issue_valid   (mul_issue_valid),
        .issue_ready   (mul_issue_ready),
        .issue_ops     (mul_issue_ops),
        .issue_payload (mul_issue_payload)
    );

    reservation_station #(
        .DEPTH     (`DIV_RS_DEPTH),
        .payload_t (rs_pkg::muldiv_payload_t)
    ) u_div_rs (
        .clk           (clk),
        .reset         (reset),
        .write_valid   (div_write_valid),
        .write_ready   (div_write_ready),
        .write_ops     (div_write_ops),
        .write_payload (div_write_payload),
        .cdb           (cdb),
        .issue_valid   (div_issue_valid),
        .issue_ready   (div_issue_ready),
        .issue_ops     (div_issue_ops),
        .issue_payload (div_issue_payload)
    );

    reservation_station #(
        .DEPTH     (`BR_RS_DEPTH),
        .payload_t (rs_pkg::branch_payload_t)
    ) u_br_rs (
        .clk           (clk),
        .reset         (reset),
        .write_valid   (br_write_valid),
        .write_ready   (br_write_ready),
        .write_ops     (br_write_ops),
        .write_payload (br_write_payload),
        .cdb           (cdb),
        .issue_valid   (br_issue_valid),
        .issue_ready   (br_issue_ready),
        .issue_ops     (br_issue_ops),
        .issue_payload (br_issue_payload)
    );

endmodule

/* verilog/rs_pkg.sv */
`include "rs_settings.svh"

package rs_pkg;

    localparam logic [6:0] OPC_OP        = 7'b0110011;  // R-type integer and M extension
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_BUBBLE    = 7'b0000000;  // Empty slot from rename
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // Renamed instruction as it arrives at dispatch
    typedef struct packed {
        logic [6:0]             opcode;
        logic [2:0]             funct3;
        logic [6:0]             funct7;
        logic [`RS_DATA_W-1:0]  pc;
        logic [`RS_DATA_W-1:0]  operand1;
        logic [`RS_DATA_W-1:0]  operand2;
        logic [`RS_TAG_W-1:0]   src1_tag;
        logic [`RS_TAG_W-1:0]   src2_tag;
        logic [1:0]             src_ready;   // Bit 0 source 1, bit 1 source 2
        logic [`RS_TAG_W-1:0]   rd_tag;
        logic [`RS_DATA_W-1:0]  immediate;
        logic [`RS_DATA_W-1:0]  inst_num;
        logic                   mem_to_reg;
        logic                   mem_read;
        logic                   mem_write;
        logic [3:0]             alu_op;
        logic                   alu_src1;
        logic                   alu_src2;
        logic                   jump;
        logic                   branch;
        logic                   pred_taken;
        logic                   btb_hit;
    } dispatch_t;

    // Part of an entry that CDB wakeup rewrites
    typedef struct packed {
        logic [`RS_DATA_W-1:0]  operand1;
        logic [`RS_DATA_W-1:0]  operand2;
        logic [`RS_TAG_W-1:0]   src1_tag;
        logic [`RS_TAG_W-1:0]   src2_tag;
        logic [1:0]             src_ready;
    } rs_operands_t;

    typedef struct packed {
        logic [2:0]             funct3;
        logic [3:0]             alu_op;
        logic                   alu_src1;
        logic                   alu_src2;
        logic                   mem_to_reg;
        logic                   mem_read;
        logic                   mem_write;
        logic [`RS_DATA_W-1:0]  pc;
        logic [`RS_DATA_W-1:0]  immediate;
        logic [`RS_TAG_W-1:0]   rd_tag;
        logic [`RS_DATA_W-1:0]  inst_num;
    } alu_payload_t;

    // Shared by the multiply and divide stations
    typedef struct packed {
        logic [2:0]             funct3;
        logic [`RS_TAG_W-1:0]   rd_tag;
        logic [`RS_DATA_W-1:0]  inst_num;
    } muldiv_payload_t;

    typedef struct packed {
        logic [2:0]             funct3;
        logic                   jump;
        logic                   branch;
        logic                   pred_taken;
        logic                   btb_hit;
        logic [`RS_DATA_W-1:0]  pc;
        logic [`RS_DATA_W-1:0]  immediate;
        logic [`RS_TAG_W-1:0]   rd_tag;
        logic [`RS_DATA_W-1:0]  inst_num;
    } branch_payload_t;

    typedef struct packed {
        logic                   valid;
        logic [`RS_TAG_W-1:0]   tag;
        logic [`RS_DATA_W-1:0]  data;
    } cdb_t;

endpackage
